// ==== dual_port_memory.sv ====
`timescale 1ns/10ps

module dual_port_memory #(
    parameter int addr_width = 2
) (
    input  logic                             clk,
    input  logic                             write_enable,
    input  logic [addr_width-1:0]            write_address,
    input  logic [switch_pkg::data_width-1:0] data_in,
    input  logic                             read_enable,
    input  logic [addr_width-1:0]            read_address,
    output logic [switch_pkg::data_width-1:0] data_out
);

    localparam int depth = 1 << addr_width;

    logic [switch_pkg::data_width-1:0] mem [0:depth-1];

    // Write port
    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= data_in;
        end
    end

    // Read port, word shows up the cycle after the strobe
    always_ff @(posedge clk) begin
        if (read_enable) begin
            data_out <= mem[read_address];
        end
    end

endmodule

// ==== fifo.sv ====
`timescale 1ns/10ps

module fifo #(
    parameter int addr_width      = 3,
    parameter int almost_empty_th = 2,
    parameter int almost_full_th  = 6
) (
    input  logic                              clk,
    input  logic                              reset_L,
    fifo_if.fifo                              wr,
    input  logic                              pop,
    output logic [switch_pkg::data_width-1:0] data_out,
    output logic                              empty,
    output logic                              almost_empty,
    output logic                              almost_full,
    output logic [addr_width:0]               fill_level,
    output logic                              error
);

    localparam int depth = 1 << addr_width;

    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic                  full;
    logic                  push_ok;
    logic                  pop_ok;
    logic                  push_err;
    logic                  pop_err;
    switch_pkg::fifo_op_e  req_op;
    switch_pkg::fifo_op_e  acc_op;

    // Status decoded straight from the counter
    assign empty        = (fill_level == 0);
    assign almost_empty = (fill_level >= 1) && (fill_level <= almost_empty_th);
    assign almost_full  = (fill_level >= almost_full_th) && (fill_level <= depth - 1);
    assign full         = (fill_level == depth);
    assign wr.full      = full;
    assign wr.pause     = (fill_level >= almost_full_th);

    // Requested operation from the two strobes
    always_comb begin
        case ({pop, wr.push})
            2'b01:   req_op = switch_pkg::op_push;
            2'b10:   req_op = switch_pkg::op_pop;
            2'b11:   req_op = switch_pkg::op_both;
            default: req_op = switch_pkg::op_idle;
        endcase
    end

    // Drop what the FIFO cannot take
    always_comb begin
        acc_op   = req_op;
        push_err = 1'b0;
        pop_err  = 1'b0;
        case (req_op)
            switch_pkg::op_push: begin
                if (full) begin
                    acc_op   = switch_pkg::op_idle;
                    push_err = 1'b1;
                end
            end
            switch_pkg::op_pop: begin
                if (empty) begin
                    acc_op  = switch_pkg::op_idle;
                    pop_err = 1'b1;
                end
            end
            switch_pkg::op_both: begin
                if (full) begin             // Only the read goes through
                    acc_op   = switch_pkg::op_pop;
                    push_err = 1'b1;
                end else if (empty) begin   // Only the write goes through
                    acc_op  = switch_pkg::op_push;
                    pop_err = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign push_ok = (acc_op == switch_pkg::op_push) || (acc_op == switch_pkg::op_both);
    assign pop_ok  = (acc_op == switch_pkg::op_pop) || (acc_op == switch_pkg::op_both);

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_level <= '0;
            error      <= 1'b0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
            case (acc_op)
                switch_pkg::op_push: fill_level <= fill_level + 1'b1;
                switch_pkg::op_pop:  fill_level <= fill_level - 1'b1;
                default:             ;   // Idle or both keeps the level
            endcase
            error <= push_err | pop_err;    // One-cycle pulse
        end
    end

    dual_port_memory #(
        .addr_width (addr_width)
    ) mem_i (
        .clk           (clk),
        .write_enable  (push_ok),
        .write_address (wr_ptr),
        .data_in       (wr.data),
        .read_enable   (pop_ok),
        .read_address  (rd_ptr),
        .data_out      (data_out)
    );

endmodule

// ==== fifo_if.sv ====
`timescale 1ns/10ps

// Push side of a FIFO
interface fifo_if;

    logic                              push;   // Write strobe
    logic [switch_pkg::data_width-1:0] data;   // Word to write
    logic                              pause;  // Level at or above almost-full threshold
    logic                              full;

    modport producer (
        output push,
        output data,
        input  pause,
        input  full
    );

    // Mirror of the producer side
    modport fifo (
        input  push,
        input  data,
        output pause,
        output full
    );

endinterface

// ==== packet_router.sv ====
`timescale 1ns/10ps

module packet_router (
    input  logic                              clk,
    input  logic                              reset_L,

    // Pop side of the ingress FIFO
    input  logic [switch_pkg::data_width-1:0] in_data,
    input  logic                              in_empty,
    output logic                              in_pop,

    // Push sides of the egress FIFOs
    fifo_if.producer                          egress0,
    fifo_if.producer                          egress1
);

    logic in_valid;     // Popped word is on in_data this cycle
    logic to_port1;

    // Stop popping as soon as either egress asks for a pause
    assign in_pop = !in_empty && !egress0.pause && !egress1.pause;

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= in_pop;     // Ingress read data lags the pop by one cycle
        end
    end

    assign to_port1 = in_data[switch_pkg::dest_bit];

    // Steer the word by its destination bit
    assign egress0.push = in_valid && !to_port1;
    assign egress1.push = in_valid && to_port1;

    // Both ports see the word, only the selected one gets the strobe
    assign egress0.data = in_data;
    assign egress1.data = in_data;

endmodule

// ==== switch_pkg.sv ====
package switch_pkg;

    // Width of every data word in the switch
    localparam int data_width = 6;

    // Bit of the word that selects the egress port
    // 0 goes to egress 0, 1 goes to egress 1
    localparam int dest_bit = 5;

    // FIFO operation requested or accepted in one cycle
    typedef enum logic [1:0] {
        op_idle = 2'b00,    // No strobe
        op_push = 2'b01,    // Write only
        op_pop  = 2'b10,    // Read only
        op_both = 2'b11     // Write and read together
    } fifo_op_e;

endpackage

// ==== switch_top.sv ====
`timescale 1ns/10ps

module switch_top #(
    parameter int in_addr_width      = 3,
    parameter int in_almost_empty_th = 2,
    parameter int in_almost_full_th  = 6,
    parameter int eg_addr_width      = 2,
    parameter int eg_almost_empty_th = 1,
    parameter int eg_almost_full_th  = 2
) (
    input  logic                              clk,
    input  logic                              reset_L,

    // Switch input
    input  logic                              push,
    input  logic [switch_pkg::data_width-1:0] data_in,
    output logic                              in_full,
    output logic                              in_pause,
    output logic                              in_almost_full,
    output logic                              in_error,

    // Egress pop sides
    input  logic                              pop0,
    input  logic                              pop1,
    output logic [switch_pkg::data_width-1:0] data_out0,
    output logic [switch_pkg::data_width-1:0] data_out1,
    output logic                              empty0,
    output logic                              empty1,
    output logic                              almost_empty0,
    output logic                              almost_empty1,
    output logic                              almost_full0,
    output logic                              almost_full1,
    output logic [eg_addr_width:0]            fill_level0,
    output logic [eg_addr_width:0]            fill_level1,
    output logic                              error0,
    output logic                              error1
);

    logic [switch_pkg::data_width-1:0] ing_data;
    logic                              ing_empty;
    logic                              ing_pop;

    fifo_if in_if ();
    fifo_if eg0_if ();
    fifo_if eg1_if ();

    // Input ports onto the ingress push side
    assign in_if.push = push;
    assign in_if.data = data_in;
    assign in_full    = in_if.full;
    assign in_pause   = in_if.pause;

    fifo #(
        .addr_width      (in_addr_width),
        .almost_empty_th (in_almost_empty_th),
        .almost_full_th  (in_almost_full_th)
    ) ingress_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .wr           (in_if),
        .pop          (ing_pop),
        .data_out     (ing_data),
        .empty        (ing_empty),
        .almost_empty (),
        .almost_full  (in_almost_full),
        .fill_level   (),
        .error        (in_error)
    );

    packet_router router_i (
        .clk      (clk),
        .reset_L  (reset_L),
        .in_data  (ing_data),
        .in_empty (ing_empty),
        .in_pop   (ing_pop),
        .egress0  (eg0_if),
        .egress1  (eg1_if)
    );

    fifo #(
        .addr_width      (eg_addr_width),
        .almost_empty_th (eg_almost_empty_th),
        .almost_full_th  (eg_almost_full_th)
    ) egress0_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .wr           (eg0_if),
        .pop          (pop0),
        .data_out     (data_out0),
        .empty        (empty0),
        .almost_empty (almost_empty0),
        .almost_full  (almost_full0),
        .fill_level   (fill_level0),
        .error        (error0)
    );

    fifo #(
        .addr_width      (eg_addr_width),
        .almost_empty_th (eg_almost_empty_th),
        .almost_full_th  (eg_almost_full_th)
    ) egress1_fifo (
        .clk          (clk),
        .reset_L      (reset_L),
        .wr           (eg1_if),
        .pop          (pop1),
        .data_out     (data_out1),
        .empty        (empty1),
        .almost_empty (almost_empty1),
        .almost_full  (almost_full1),
        .fill_level   (fill_level1),
        .error        (error1)
    );

endmodule

// ==== tb_switch.sv ====
`timescale 1ns/10ps

module tb_switch;

    localparam int reset_cycles = 10;
    localparam int mix_cycles   = 700;  // Random pushes and pops
    localparam int hold_cycles  = 200;  // Egress pops held low
    localparam int hard_cycles  = 500;  // Pops every cycle
    localparam int drain_cycles = 90;
    localparam int max_cycles   = 2 * (reset_cycles + mix_cycles + hold_cycles
                                       + hard_cycles + drain_cycles);

    localparam int in_depth = 8;
    localparam int in_af_th = 6;
    localparam int eg_depth = 4;
    localparam int eg_ae_th = 1;
    localparam int eg_af_th = 2;

    logic       clk = 1'b0;
    logic       reset_L;
    logic       push;
    logic [5:0] data_in;
    logic       in_full;
    logic       in_pause;
    logic       in_almost_full;
    logic       in_error;
    logic       pop0;
    logic       pop1;
    logic [5:0] data_out0;
    logic [5:0] data_out1;
    logic       empty0;
    logic       empty1;
    logic       almost_empty0;
    logic       almost_empty1;
    logic       almost_full0;
    logic       almost_full1;
    logic [2:0] fill_level0;
    logic [2:0] fill_level1;
    logic       error0;
    logic       error1;

    int         seed = 32'h443a4375;
    int         cycle_count = 0;
    int         in_level = 0;   // Words held by the ingress FIFO

    // Expected words per destination, oldest first
    logic [5:0] sb0 [$];
    logic [5:0] sb1 [$];
    int         pending0 = 0;
    int         pending1 = 0;
    logic       chk0;
    logic       chk1;
    logic [5:0] exp0;
    logic [5:0] exp1;

    always #5 clk = ~clk;

    switch_top switch_top_i (.*);

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("ERROR: %s expected %0h actual %0h", name, expected, actual);
        fail_run();
    endtask

    task automatic abort_run(string why);
        $display("ERROR: %s", why);
        fail_run();
    endtask

    // {empty, almost_empty, almost_full} for an egress level
    function automatic logic [2:0] expected_flags(logic [2:0] level);
        expected_flags = {level == 0,
                          (level >= 1) && (level <= eg_ae_th),
                          (level >= eg_af_th) && (level <= eg_depth - 1)};
    endfunction

    // {full, pause, almost_full} for an ingress level
    function automatic logic [2:0] ingress_flags(int level);
        ingress_flags = {level == in_depth,
                         level >= in_af_th,
                         (level >= in_af_th) && (level <= in_depth - 1)};
    endfunction

    // Random strobes for a number of cycles, odds in percent
    task automatic run_phase(int cycles, int push_odds, int pop_odds);
        repeat (cycles) begin
            @(negedge clk);
            push    = ($unsigned($random(seed)) % 100) < push_odds;
            data_in = $random(seed);
            pop0    = ($unsigned($random(seed)) % 100) < pop_odds;
            pop1    = ($unsigned($random(seed)) % 100) < pop_odds;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            abort_run("cycle limit reached before all tests finished");
        end
    end

    // Scoreboard, words enter on accepted input pushes
    always @(posedge clk) begin
        if (!reset_L) begin
            chk0     <= 1'b0;
            chk1     <= 1'b0;
            in_level <= 0;
        end else begin
            if (push && !in_full) begin
                if (data_in[switch_pkg::dest_bit]) sb1.push_back(data_in);
                else sb0.push_back(data_in);
            end
            // Push refused at depth, router pop refused at zero
            in_level <= in_level + (push && in_level != in_depth)
                        - (switch_top_i.ing_pop && in_level != 0);
            chk0 <= 1'b0;
            chk1 <= 1'b0;
            if (pop0 && !empty0 && sb0.size() > 0) begin
                chk0 <= 1'b1;
                exp0 <= sb0.pop_front();    // Compared one cycle later
            end
            if (pop1 && !empty1 && sb1.size() > 0) begin
                chk1 <= 1'b1;
                exp1 <= sb1.pop_front();
            end
            pending0 = sb0.size();
            pending1 = sb1.size();
        end
    end

    // State right after reset
    reset_levels: assert property (@(posedge clk) $rose(reset_L) |->
        {fill_level0, fill_level1} == 6'h00)
        else report_mismatch("fill_level0/fill_level1", 0, $sampled({fill_level0, fill_level1}));
    reset_empty: assert property (@(posedge clk) $rose(reset_L) |-> {empty0, empty1} == 2'b11)
        else report_mismatch("empty0/empty1", 3, $sampled({empty0, empty1}));
    reset_flags: assert property (@(posedge clk) $rose(reset_L) |->
        {in_full, in_pause, in_almost_full, in_error, almost_empty0, almost_empty1,
         almost_full0, almost_full1, error0, error1} == 10'h000)
        else report_mismatch("status flags", 0, $sampled({in_full, in_pause, in_almost_full,
            in_error, almost_empty0, almost_empty1, almost_full0, almost_full1, error0, error1}));

    // Ingress side
    in_err_pulse: assert property (@(posedge clk) disable iff (!reset_L)
        in_error == $past(push && in_full))
        else report_mismatch("in_error", !$sampled(in_error), $sampled(in_error));
    in_flags: assert property (@(posedge clk) disable iff (!reset_L)
        {in_full, in_pause, in_almost_full} == ingress_flags(in_level))
        else report_mismatch("in_full/in_pause/in_almost_full",
            ingress_flags($sampled(in_level)),
            $sampled({in_full, in_pause, in_almost_full}));

    // Egress 0
    data0: assert property (@(posedge clk) disable iff (!reset_L) chk0 |-> data_out0 == exp0)
        else report_mismatch("data_out0", $sampled(exp0), $sampled(data_out0));
    extra0: assert property (@(posedge clk) disable iff (!reset_L)
        pop0 && !empty0 |-> pending0 != 0)
        else abort_run("egress 0 delivered a word that was never pushed");
    idle0: assert property (@(posedge clk) disable iff (!reset_L) pending0 == 0 |-> empty0)
        else report_mismatch("empty0", 1, $sampled(empty0));
    err0: assert property (@(posedge clk) disable iff (!reset_L)
        error0 == $past(pop0 && empty0))
        else report_mismatch("error0", !$sampled(error0), $sampled(error0));
    keep0: assert property (@(posedge clk) disable iff (!reset_L)
        pop0 && empty0 && !switch_top_i.eg0_if.push |=> fill_level0 == 0)
        else report_mismatch("fill_level0", 0, $sampled(fill_level0));
    flags0: assert property (@(posedge clk) disable iff (!reset_L)
        {empty0, almost_empty0, almost_full0} == expected_flags(fill_level0))
        else report_mismatch("empty0/almost_empty0/almost_full0",
            expected_flags($sampled(fill_level0)),
            $sampled({empty0, almost_empty0, almost_full0}));
    // Pause stops the router before the FIFO fills
    max0: assert property (@(posedge clk) disable iff (!reset_L) fill_level0 < eg_depth)
        else report_mismatch("fill_level0", eg_depth - 1, $sampled(fill_level0));

    // Egress 1
    data1: assert property (@(posedge clk) disable iff (!reset_L) chk1 |-> data_out1 == exp1)
        else report_mismatch("data_out1", $sampled(exp1), $sampled(data_out1));
    extra1: assert property (@(posedge clk) disable iff (!reset_L)
        pop1 && !empty1 |-> pending1 != 0)
        else abort_run("egress 1 delivered a word that was never pushed");
    idle1: assert property (@(posedge clk) disable iff (!reset_L) pending1 == 0 |-> empty1)
        else report_mismatch("empty1", 1, $sampled(empty1));
    err1: assert property (@(posedge clk) disable iff (!reset_L)
        error1 == $past(pop1 && empty1))
        else report_mismatch("error1", !$sampled(error1), $sampled(error1));
    keep1: assert property (@(posedge clk) disable iff (!reset_L)
        pop1 && empty1 && !switch_top_i.eg1_if.push |=> fill_level1 == 0)
        else report_mismatch("fill_level1", 0, $sampled(fill_level1));
    flags1: assert property (@(posedge clk) disable iff (!reset_L)
        {empty1, almost_empty1, almost_full1} == expected_flags(fill_level1))
        else report_mismatch("empty1/almost_empty1/almost_full1",
            expected_flags($sampled(fill_level1)),
            $sampled({empty1, almost_empty1, almost_full1}));
    max1: assert property (@(posedge clk) disable iff (!reset_L) fill_level1 < eg_depth)
        else report_mismatch("fill_level1", eg_depth - 1, $sampled(fill_level1));

    initial begin
        reset_L = 1'b0;
        push    = 1'b0;
        data_in = '0;
        pop0    = 1'b0;
        pop1    = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk) reset_L = 1'b1;

        run_phase(mix_cycles, 50, 40);
        run_phase(hold_cycles, 80, 0);      // Back-pressure fills the ingress FIFO
        hold_full: assert (in_full)
            else report_mismatch("in_full", 1, in_full);
        run_phase(hard_cycles, 50, 100);

        // Drain everything still in flight
        @(negedge clk);
        push = 1'b0;
        pop0 = 1'b1;
        pop1 = 1'b1;
        while (sb0.size() != 0 || sb1.size() != 0) @(negedge clk);
        repeat (5) @(negedge clk);          // Last compares and empty checks

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== vlog.f ====
switch_pkg.sv
dual_port_memory.sv
fifo_if.sv
fifo.sv
packet_router.sv
switch_top.sv
tb_switch.sv
